// File: hdl/anneal_ctrl.sv
////////////////////////////////////////////////////////////
// Anneal controller
// Steps through idle, sweep, drain, commit and done
////////////////////////////////////////////////////////////
module anneal_ctrl import ising_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic start_i,
    input  logic iter_zero_i,
    input  logic spin_last_i,
    input  logic iter_last_i,
    output logic cnt_clear_o,
    output logic spin_step_o,
    output logic iter_step_o,
    output logic j_ren_o,
    output logic flip_ren_o,
    output logic load_o,
    output logic stage_o,
    output logic commit_o,
    output logic busy_o,
    output logic done_o
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        accept;
    logic        stage_q;
    logic        first_q;

    // Start only counts in IDLE
    assign accept = (state_q == IDLE) && start_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d = iter_zero_i ? DONE : SWEEP;
                end
            end
            SWEEP: begin
                if (spin_last_i) begin
                    state_d = DRAIN;
                end
            end
            DRAIN:   state_d = COMMIT;
            COMMIT: begin
                state_d = iter_last_i ? DONE : SWEEP;
            end
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            stage_q <= 1'b0;
            first_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Read data lands one cycle after the weight read
            stage_q <= (state_q == SWEEP);
            first_q <= (state_d == SWEEP) && (state_q != SWEEP);
        end
    end

    assign cnt_clear_o = accept;
    assign load_o      = accept;
    assign spin_step_o = (state_q == SWEEP);
    assign j_ren_o     = (state_q == SWEEP);
    // Icon fetched once in the first sweep cycle
    assign flip_ren_o  = first_q;
    assign stage_o     = stage_q;
    assign commit_o    = (state_q == COMMIT);
    assign iter_step_o = (state_q == COMMIT);
    assign busy_o      = (state_q != IDLE);
    assign done_o      = (state_q == DONE);

endmodule

// File: hdl/field_unit.sv
////////////////////////////////////////////////////////////
// Field unit
// Local field per spin, sign decision and sweep energy
////////////////////////////////////////////////////////////
module field_unit import ising_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       valid_i,
    input  logic                       first_i,
    input  j_row_u                     row_i,
    input  spin_vec_t                  spins_i,
    input  logic [SPIN_IDX_W-1:0]      stage_idx_i,
    output logic                       new_spin_o,
    output logic signed [ENERGY_W-1:0] energy_o
);

    logic signed [FIELD_W-1:0]  h;
    logic signed [ENERGY_W-1:0] h_ext;
    logic signed [ENERGY_W-1:0] term;
    logic signed [ENERGY_W-1:0] acc_next;
    logic signed [ENERGY_W-1:0] acc_q;
    logic signed [ENERGY_W-1:0] energy_q;
    logic                       spin_old;
    logic                       last;

    ////////////////////////////////////////////////////////////
    // Local field
    ////////////////////////////////////////////////////////////
    always_comb begin
        h = '0;
        for (int k = 0; k < NUM_SPIN; k++) begin
            if (spins_i[k]) begin
                h = h + $signed(row_i.w[k]);
            end else begin
                h = h - $signed(row_i.w[k]);
            end
        end
    end

    assign spin_old = spins_i[stage_idx_i];

    // Zero field keeps the spin
    always_comb begin
        if (h > 0) begin
            new_spin_o = 1'b1;
        end else if (h < 0) begin
            new_spin_o = 1'b0;
        end else begin
            new_spin_o = spin_old;
        end
    end

    ////////////////////////////////////////////////////////////
    // Energy
    ////////////////////////////////////////////////////////////
    assign h_ext    = h;
    // Contribution is -s*h
    assign term     = spin_old ? -h_ext : h_ext;
    assign acc_next = first_i ? term : acc_q + term;
    assign last     = (stage_idx_i == SPIN_IDX_W'(NUM_SPIN - 1));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc_q    <= '0;
            energy_q <= '0;
        end else if (valid_i) begin
            acc_q <= acc_next;
            // Result held until the next sweep finishes
            if (last) begin
                energy_q <= acc_next;
            end
        end
    end

    assign energy_o = energy_q;

endmodule

// File: hdl/ising_core.sv
////////////////////////////////////////////////////////////
// Ising annealing core
// Weight and icon memories, sweep control and spin update
////////////////////////////////////////////////////////////
module ising_core import ising_pkg::*; #(
    parameter int FLIP_DEPTH = 16,
    parameter int ITER_W     = 8
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    // Weight memory load
    input  logic                          j_we_i,
    input  logic [SPIN_IDX_W-1:0]         j_waddr_i,
    input  j_row_u                        j_wdata_i,
    // Flip icon memory load
    input  logic                          flip_we_i,
    input  logic [$clog2(FLIP_DEPTH)-1:0] flip_waddr_i,
    input  spin_vec_t                     flip_wdata_i,
    // Run setup
    input  logic                          cmpt_start_i,
    input  spin_vec_t                     spin_init_i,
    input  logic [ITER_W-1:0]             iter_num_i,
    input  logic [$clog2(FLIP_DEPTH)-1:0] icon_last_i,
    input  logic                          flip_en_i,
    // Results and status
    output spin_vec_t                     spins_o,
    output logic signed [ENERGY_W-1:0]    energy_o,
    output logic                          energy_valid_o,
    output logic                          busy_o,
    output logic                          done_o
);

    // Controller strobes
    logic cnt_clear;
    logic spin_step;
    logic iter_step;
    logic j_ren;
    logic flip_ren;
    logic load;
    logic stage;
    logic commit;

    // Counter outputs
    logic [SPIN_IDX_W-1:0]         spin_idx;
    logic [SPIN_IDX_W-1:0]         stage_idx;
    logic [$clog2(FLIP_DEPTH)-1:0] icon_addr;
    logic                          spin_last;
    logic                          iter_last;
    logic                          iter_zero;
    logic                          stage_first;

    // Data path
    j_row_u    j_rdata;
    spin_vec_t flip_rdata;
    logic      new_spin;

    // Run settings held for the whole run
    logic [$clog2(FLIP_DEPTH)-1:0] icon_last_q;
    logic                          flip_en_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            icon_last_q <= '0;
            flip_en_q   <= 1'b0;
        end else if (cnt_clear) begin
            icon_last_q <= icon_last_i;
            flip_en_q   <= flip_en_i;
        end
    end

    assign stage_first    = (stage_idx == '0);
    assign energy_valid_o = commit;

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////
    anneal_ctrl u_ctrl (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .start_i     (cmpt_start_i),
        .iter_zero_i (iter_zero),
        .spin_last_i (spin_last),
        .iter_last_i (iter_last),
        .cnt_clear_o (cnt_clear),
        .spin_step_o (spin_step),
        .iter_step_o (iter_step),
        .j_ren_o     (j_ren),
        .flip_ren_o  (flip_ren),
        .load_o      (load),
        .stage_o     (stage),
        .commit_o    (commit),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    sweep_counter #(
        .ITER_W     (ITER_W),
        .FLIP_DEPTH (FLIP_DEPTH)
    ) u_counter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .clear_i     (cnt_clear),
        .spin_step_i (spin_step),
        .iter_step_i (iter_step),
        .iter_num_i  (iter_num_i),
        .icon_last_i (icon_last_q),
        .spin_idx_o  (spin_idx),
        .stage_idx_o (stage_idx),
        .icon_addr_o (icon_addr),
        .spin_last_o (spin_last),
        .iter_last_o (iter_last),
        .iter_zero_o (iter_zero)
    );

    ////////////////////////////////////////////////////////////
    // Memories
    ////////////////////////////////////////////////////////////
    l1_ram #(
        .DATA_W (ROW_W),
        .DEPTH  (NUM_SPIN)
    ) u_j_mem (
        .clk_i   (clk_i),
        .we_i    (j_we_i),
        .waddr_i (j_waddr_i),
        .wdata_i (j_wdata_i.flat),
        .re_i    (j_ren),
        .raddr_i (spin_idx),
        .rdata_o (j_rdata)
    );

    l1_ram #(
        .DATA_W (NUM_SPIN),
        .DEPTH  (FLIP_DEPTH)
    ) u_flip_mem (
        .clk_i   (clk_i),
        .we_i    (flip_we_i),
        .waddr_i (flip_waddr_i),
        .wdata_i (flip_wdata_i),
        .re_i    (flip_ren),
        .raddr_i (icon_addr),
        .rdata_o (flip_rdata)
    );

    ////////////////////////////////////////////////////////////
    // Data path
    ////////////////////////////////////////////////////////////
    field_unit u_field (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .valid_i     (stage),
        .first_i     (stage_first),
        .row_i       (j_rdata),
        .spins_i     (spins_o),
        .stage_idx_i (stage_idx),
        .new_spin_o  (new_spin),
        .energy_o    (energy_o)
    );

    spin_reg u_spins (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .load_i      (load),
        .init_i      (spin_init_i),
        .stage_i     (stage),
        .stage_idx_i (stage_idx),
        .new_spin_i  (new_spin),
        .commit_i    (commit),
        .flip_en_i   (flip_en_q),
        .flip_mask_i (flip_rdata),
        .spins_o     (spins_o)
    );

endmodule

// File: hdl/ising_pkg.sv
////////////////////////////////////////////////////////////
// Ising core package
// Problem size, derived widths and shared types
////////////////////////////////////////////////////////////
package ising_pkg;

    ////////////////////////////////////////////////////////////
    // Problem size
    ////////////////////////////////////////////////////////////
    parameter int NUM_SPIN = 8;
    parameter int BIT_J    = 4;

    ////////////////////////////////////////////////////////////
    // Derived widths
    ////////////////////////////////////////////////////////////
    parameter int SPIN_IDX_W = $clog2(NUM_SPIN);
    // Sign bit plus growth for NUM_SPIN weight terms
    parameter int FIELD_W    = BIT_J + SPIN_IDX_W + 1;
    parameter int ENERGY_W   = FIELD_W + SPIN_IDX_W;
    parameter int ROW_W      = NUM_SPIN * BIT_J;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////
    // Bit set means +1, bit clear means -1
    typedef logic [NUM_SPIN-1:0] spin_vec_t;

    // One coupling row as the host's flat word or the field unit's weights
    typedef union packed {
        logic [ROW_W-1:0]                flat;
        logic [NUM_SPIN-1:0][BIT_J-1:0]  w;
    } j_row_u;

    typedef enum logic [2:0] {
        IDLE,
        SWEEP,
        DRAIN,
        COMMIT,
        DONE
    } ctrl_state_t;

endpackage

// File: hdl/l1_ram.sv
////////////////////////////////////////////////////////////
// L1 memory with one write port and a registered read port
////////////////////////////////////////////////////////////
module l1_ram #(
    parameter int DATA_W = 32,
    parameter int DEPTH  = 16
) (
    input  logic                     clk_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  logic [DATA_W-1:0]        wdata_i,
    input  logic                     re_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output logic [DATA_W-1:0]        rdata_o
);

    logic [DATA_W-1:0] mem_q [DEPTH];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // Read data stays put until the next read
    always_ff @(posedge clk_i) begin
        if (re_i) begin
            rdata_o <= mem_q[raddr_i];
        end
    end

endmodule

// File: hdl/spin_reg.sv
////////////////////////////////////////////////////////////
// Spin register
// Committed spin state and the copy staged during a sweep
////////////////////////////////////////////////////////////
module spin_reg import ising_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  load_i,
    input  spin_vec_t             init_i,
    input  logic                  stage_i,
    input  logic [SPIN_IDX_W-1:0] stage_idx_i,
    input  logic                  new_spin_i,
    input  logic                  commit_i,
    input  logic                  flip_en_i,
    input  spin_vec_t             flip_mask_i,
    output spin_vec_t             spins_o
);

    spin_vec_t state_q;
    spin_vec_t staged_q;
    spin_vec_t commit_val;

    // Icon applied on top of the new spins
    assign commit_val = flip_en_i ? (staged_q ^ flip_mask_i) : staged_q;

    ////////////////////////////////////////////////////////////
    // Committed state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= '0;
        end else if (load_i) begin
            state_q <= init_i;
        end else if (commit_i) begin
            state_q <= commit_val;
        end
    end

    ////////////////////////////////////////////////////////////
    // Staged copy
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (stage_i) begin
            // One spin per cycle in sweep order
            staged_q[stage_idx_i] <= new_spin_i;
        end
    end

    assign spins_o = state_q;

endmodule

// File: hdl/sweep_counter.sv
////////////////////////////////////////////////////////////
// Sweep counters
// Spin index, stage position, iteration and icon address
////////////////////////////////////////////////////////////
module sweep_counter import ising_pkg::*; #(
    parameter int ITER_W     = 8,
    parameter int FLIP_DEPTH = 16
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          clear_i,
    input  logic                          spin_step_i,
    input  logic                          iter_step_i,
    input  logic [ITER_W-1:0]             iter_num_i,
    input  logic [$clog2(FLIP_DEPTH)-1:0] icon_last_i,
    output logic [SPIN_IDX_W-1:0]         spin_idx_o,
    output logic [SPIN_IDX_W-1:0]         stage_idx_o,
    output logic [$clog2(FLIP_DEPTH)-1:0] icon_addr_o,
    output logic                          spin_last_o,
    output logic                          iter_last_o,
    output logic                          iter_zero_o
);

    logic [SPIN_IDX_W-1:0]         spin_idx_q;
    logic [SPIN_IDX_W-1:0]         stage_idx_q;
    logic [ITER_W-1:0]             iter_cnt_q;
    logic [ITER_W-1:0]             iter_num_q;
    logic [$clog2(FLIP_DEPTH)-1:0] icon_addr_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            spin_idx_q  <= '0;
            stage_idx_q <= '0;
            iter_cnt_q  <= '0;
            iter_num_q  <= '0;
            icon_addr_q <= '0;
        end else begin
            stage_idx_q <= spin_idx_q;
            if (clear_i) begin
                spin_idx_q  <= '0;
                iter_cnt_q  <= '0;
                iter_num_q  <= iter_num_i;
                icon_addr_q <= '0;
            end else begin
                if (spin_step_i) begin
                    spin_idx_q <= spin_last_o ? '0 : spin_idx_q + 1'b1;
                end
                if (iter_step_i) begin
                    iter_cnt_q  <= iter_cnt_q + 1'b1;
                    // Icon wraps after the last loaded address
                    icon_addr_q <= (icon_addr_q == icon_last_i) ? '0 : icon_addr_q + 1'b1;
                end
            end
        end
    end

    assign spin_idx_o  = spin_idx_q;
    assign stage_idx_o = stage_idx_q;
    assign icon_addr_o = icon_addr_q;
    assign spin_last_o = (spin_idx_q == SPIN_IDX_W'(NUM_SPIN - 1));
    assign iter_last_o = ((iter_cnt_q + ITER_W'(1)) == iter_num_q);
    assign iter_zero_o = (iter_num_i == '0);

endmodule

// File: tb.f
+incdir+tests
hdl/ising_pkg.sv
hdl/l1_ram.sv
hdl/sweep_counter.sv
hdl/anneal_ctrl.sv
hdl/field_unit.sv
hdl/spin_reg.sv
hdl/ising_core.sv
tests/tb_ising_core.sv

// File: tests/ising_model.svh
////////////////////////////////////////////////////////////
// Ising reference model
// Sweep, sweep energy and LFSR for the testbench
////////////////////////////////////////////////////////////
`ifndef ISING_MODEL_SVH
`define ISING_MODEL_SVH

// Element k of row i couples spin i to spin k
typedef logic [NUM_SPIN-1:0][NUM_SPIN-1:0][BIT_J-1:0] j_mat_t;

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

function automatic int local_field(input j_mat_t jm, input spin_vec_t s, input int i);
    int h;
    int w;
    h = 0;
    for (int k = 0; k < NUM_SPIN; k++) begin
        w = int'($signed(jm[i][k]));
        h = s[k] ? h + w : h - w;
    end
    return h;
endfunction

// New spins all decided from the entering state
function automatic spin_vec_t sweep_spins(input j_mat_t jm, input spin_vec_t s);
    spin_vec_t ns;
    int        h;
    for (int i = 0; i < NUM_SPIN; i++) begin
        h = local_field(jm, s, i);
        if (h > 0) begin
            ns[i] = 1'b1;
        end else if (h < 0) begin
            ns[i] = 1'b0;
        end else begin
            ns[i] = s[i];
        end
    end
    return ns;
endfunction

// Negated sum of s_i * h_i
function automatic int sweep_energy(input j_mat_t jm, input spin_vec_t s);
    int e;
    int h;
    e = 0;
    for (int i = 0; i < NUM_SPIN; i++) begin
        h = local_field(jm, s, i);
        e = s[i] ? e - h : e + h;
    end
    return e;
endfunction

`endif

// File: tests/tb_ising_core.sv
////////////////////////////////////////////////////////////
// Testbench for the Ising annealing core
// Loads random weights and icons, runs anneals, checks results
////////////////////////////////////////////////////////////
module tb_ising_core import ising_pkg::*;;

    localparam int FLIP_DEPTH   = 16;
    localparam int ITER_W       = 8;
    localparam int ICON_W       = $clog2(FLIP_DEPTH);
    localparam int DRV          = 1;
    localparam int RESET_CYCLES = 4;
    localparam int ITER_LEN     = NUM_SPIN + 2;
    localparam int ITERS_ONE    = 1;
    localparam int ITERS_FLIP   = 5;
    localparam int ITERS_BUSY   = 3;
    localparam int TOTAL_ITERS  = ITERS_ONE + ITERS_FLIP + ITERS_BUSY;
    // Reset, loads, three cycles of overhead per run, iterations, margin
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_SPIN + FLIP_DEPTH + 4 * 3
                                   + TOTAL_ITERS * ITER_LEN + 100;

    logic                       clk_i;
    logic                       rst_n_i;
    logic                       j_we_i;
    logic [SPIN_IDX_W-1:0]      j_waddr_i;
    j_row_u                     j_wdata_i;
    logic                       flip_we_i;
    logic [ICON_W-1:0]          flip_waddr_i;
    spin_vec_t                  flip_wdata_i;
    logic                       cmpt_start_i;
    spin_vec_t                  spin_init_i;
    logic [ITER_W-1:0]          iter_num_i;
    logic [ICON_W-1:0]          icon_last_i;
    logic                       flip_en_i;
    spin_vec_t                  spins_o;
    logic signed [ENERGY_W-1:0] energy_o;
    logic                       energy_valid_o;
    logic                       busy_o;
    logic                       done_o;

    int          value_errs = 0;
    int          other_errs = 0;
    logic [31:0] lfsr_q;
    spin_vec_t   icons [FLIP_DEPTH];

    `include "ising_model.svh"

    j_mat_t j_mat;

    ising_core #(
        .FLIP_DEPTH (FLIP_DEPTH),
        .ITER_W     (ITER_W)
    ) dut_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .j_we_i         (j_we_i),
        .j_waddr_i      (j_waddr_i),
        .j_wdata_i      (j_wdata_i),
        .flip_we_i      (flip_we_i),
        .flip_waddr_i   (flip_waddr_i),
        .flip_wdata_i   (flip_wdata_i),
        .cmpt_start_i   (cmpt_start_i),
        .spin_init_i    (spin_init_i),
        .iter_num_i     (iter_num_i),
        .icon_last_i    (icon_last_i),
        .flip_en_i      (flip_en_i),
        .spins_o        (spins_o),
        .energy_o       (energy_o),
        .energy_valid_o (energy_valid_o),
        .busy_o         (busy_o),
        .done_o         (done_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            bits   = {bits[30:0], lfsr_q[0]};
        end
        return bits;
    endfunction

    ////////////////////////////////////////////////////////////
    // Memory loading
    ////////////////////////////////////////////////////////////
    task automatic load_weights();
        logic [BIT_J-1:0] w;
        j_mat = '0;
        // Symmetric couplings with a zero diagonal
        for (int i = 0; i < NUM_SPIN; i++) begin
            for (int k = i + 1; k < NUM_SPIN; k++) begin
                w           = BIT_J'(take_bits(BIT_J));
                j_mat[i][k] = w;
                j_mat[k][i] = w;
            end
        end
        for (int i = 0; i < NUM_SPIN; i++) begin
            @(posedge clk_i);
            #DRV;
            j_we_i         = 1'b1;
            j_waddr_i      = SPIN_IDX_W'(i);
            j_wdata_i.flat = j_mat[i];
        end
        @(posedge clk_i);
        #DRV;
        j_we_i = 1'b0;
    endtask

    task automatic load_icons();
        for (int a = 0; a < FLIP_DEPTH; a++) begin
            @(posedge clk_i);
            #DRV;
            icons[a]     = spin_vec_t'(take_bits(NUM_SPIN));
            flip_we_i    = 1'b1;
            flip_waddr_i = ICON_W'(a);
            flip_wdata_i = icons[a];
        end
        @(posedge clk_i);
        #DRV;
        flip_we_i = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // One anneal run against the model
    ////////////////////////////////////////////////////////////
    task automatic run_anneal(input spin_vec_t init, input int n, input int last,
                              input logic fen, input logic extra);
        spin_vec_t s;
        int        exp_e [$];
        int        cyc;
        int        pulses;
        int        limit;
        logic      seen_done;
        s = init;
        for (int t = 0; t < n; t++) begin
            exp_e.push_back(sweep_energy(j_mat, s));
            s = sweep_spins(j_mat, s);
            if (fen) begin
                s = s ^ icons[t % (last + 1)];
            end
        end
        @(posedge clk_i);
        #DRV;
        spin_init_i  = init;
        iter_num_i   = ITER_W'(n);
        icon_last_i  = ICON_W'(last);
        flip_en_i    = fen;
        cmpt_start_i = 1'b1;
        cyc       = 0;
        pulses    = 0;
        seen_done = 1'b0;
        limit     = 1 + n * ITER_LEN + 20;
        while (!seen_done && cyc < limit) begin
            @(posedge clk_i);
            #DRV;
            cmpt_start_i = 1'b0;
            cyc++;
            assert (busy_o) else begin
                other_errs++;
                $display("busy_o low %0d cycles after the start", cyc);
            end
            if (energy_valid_o) begin
                if (pulses < n) begin
                    assert (energy_o == exp_e[pulses]) else begin
                        value_errs++;
                        $display("ERROR: energy_o = %h, expected %h (iteration %0d)",
                                 energy_o, ENERGY_W'(exp_e[pulses]), pulses);
                    end
                end
                pulses++;
            end
            if (done_o) begin
                seen_done = 1'b1;
                assert (cyc == 1 + n * ITER_LEN) else begin
                    other_errs++;
                    $display("done_o came %0d cycles after start, expected %0d",
                             cyc, 1 + n * ITER_LEN);
                end
                assert (spins_o == s) else begin
                    value_errs++;
                    $display("ERROR: spins_o = %h, expected %h", spins_o, s);
                end
                assert (pulses == n) else begin
                    other_errs++;
                    $display("Saw %0d energy_valid_o pulses for %0d iterations", pulses, n);
                end
            end else if (extra && busy_o && (cyc % 3 == 0)) begin
                // Stray start with unrelated settings
                cmpt_start_i = 1'b1;
                spin_init_i  = spin_vec_t'(take_bits(NUM_SPIN));
                iter_num_i   = ITER_W'(take_bits(ITER_W));
                icon_last_i  = ICON_W'(take_bits(ICON_W));
                flip_en_i    = ~fen;
            end
        end
        if (!seen_done) begin
            other_errs++;
            $display("No done_o within %0d cycles of the start", limit);
        end
        @(posedge clk_i);
        #DRV;
        assert (!busy_o && !done_o) else begin
            other_errs++;
            $display("Core did not return to idle one cycle after done_o");
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        lfsr_q       = 32'hac40_d713;
        rst_n_i      = 1'b0;
        j_we_i       = 1'b0;
        j_waddr_i    = '0;
        j_wdata_i    = '0;
        flip_we_i    = 1'b0;
        flip_waddr_i = '0;
        flip_wdata_i = '0;
        cmpt_start_i = 1'b0;
        spin_init_i  = '0;
        iter_num_i   = '0;
        icon_last_i  = '0;
        flip_en_i    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRV;
        assert (!busy_o && !done_o && !energy_valid_o && spins_o == '0) else begin
            other_errs++;
            $display("Outputs not cleared by reset");
        end
        rst_n_i = 1'b1;
        load_weights();
        load_icons();
        run_anneal(spin_vec_t'(take_bits(NUM_SPIN)), ITERS_ONE, 0, 1'b0, 1'b0);
        run_anneal(spin_vec_t'(take_bits(NUM_SPIN)), ITERS_FLIP, 2, 1'b1, 1'b0);
        run_anneal(spin_vec_t'(take_bits(NUM_SPIN)), ITERS_BUSY, FLIP_DEPTH - 1, 1'b1, 1'b1);
        // Zero count goes straight to done
        run_anneal(spin_vec_t'(take_bits(NUM_SPIN)), 0, 0, 1'b1, 1'b0);
        finish_run();
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        other_errs++;
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        finish_run();
    end

endmodule
